//--- Makefile
# Verilator flow for the rectangle overlay testbench
TOP := RectOverlayTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

# $fatal in the testbench makes the binary exit with a failing status
sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir

//--- flist.f
+incdir+source
source/VideoTimingPkg.sv
source/PixelPkg.sv
source/ScanIf.sv
source/ScanTimingGen.sv
source/DotSquareGen.sv
source/DotFrameGen.sv
source/LayerMixer.sv
source/RectOverlayTop.sv
tests/ClockGen.sv
tests/RectOverlayTb.sv

//--- source/DotFrameGen.sv
// ----------------------------------------------------------
// rectangle outline detector with border thickness 1..3
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module DotFrameGen
    import VideoTimingPkg::*;
    import PixelPkg::*;
(
    input  wire logic       iClk,
    input  wire logic       reset,
    ScanIf.dst              scan,
    input  wire hCoordT     xStart,     // inclusive outer bounds
    input  wire hCoordT     xEnd,
    input  wire vCoordT     yStart,
    input  wire vCoordT     yEnd,
    input  wire logic [1:0] thickness,  // border width in pixels
    input  wire pixelWordT  color,
    output pixelWordT       pixel,
    output logic            valid       // pixel on the outline
);

    // ------------------------------------------------------
    // stage 1 outer box and edge distances
    // ------------------------------------------------------
    logic   qInside;
    logic   [3:0] qNear;                // left, right, top, bottom
    hCoordT thickH;
    vCoordT thickV;
    logic   rInside;
    logic   [3:0] rNear;
    pixelWordT rColor;

    always_comb
    begin
        thickH  = hCoordT'(thickness);
        thickV  = vCoordT'(thickness);
        qInside = scan.active
                && (scan.hPos >= xStart) && (scan.hPos <= xEnd)
                && (scan.vPos >= yStart) && (scan.vPos <= yEnd);
        // wrapped differences only occur outside the box
        qNear[0] = (hCoordT'(scan.hPos - xStart) < thickH);
        qNear[1] = (hCoordT'(xEnd - scan.hPos)   < thickH);
        qNear[2] = (vCoordT'(scan.vPos - yStart) < thickV);
        qNear[3] = (vCoordT'(yEnd - scan.vPos)   < thickV);
    end

    always_ff @(posedge iClk)
    begin
        if (reset)
        begin
            rInside <= 1'b0;
            rNear   <= '0;
        end
        else
        begin
            rInside <= qInside;
            rNear   <= qNear;
        end
        rColor <= color;                    // colour first delay
    end

    // ------------------------------------------------------
    // stage 2 inside the box and close to any edge
    // ------------------------------------------------------
    always_ff @(posedge iClk)
    begin
        if (reset)
            valid <= 1'b0;
        else
            valid <= rInside && (|rNear);
        pixel <= rColor;
    end

    thicknessA: assert property (@(posedge iClk) disable iff (reset)
        thickness != 2'd0);

endmodule

`default_nettype wire

//--- source/DotSquareGen.sv
// ----------------------------------------------------------
// filled rectangle hit detector, two register stages
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module DotSquareGen
    import VideoTimingPkg::*;
    import PixelPkg::*;
(
    input  wire logic      iClk,
    input  wire logic      reset,
    ScanIf.dst             scan,
    input  wire hCoordT    xStart,     // inclusive
    input  wire hCoordT    xEnd,       // inclusive
    input  wire vCoordT    yStart,
    input  wire vCoordT    yEnd,
    input  wire pixelWordT color,      // fill colour
    output pixelWordT      pixel,
    output logic           valid       // pixel inside rectangle
);

    // ------------------------------------------------------
    // stage 1: the four bound compares
    // ------------------------------------------------------
    logic [3:0] qCke;
    logic [3:0] rCke;
    pixelWordT  rColor;                     // colour, first delay

    always_comb
    begin
        qCke[0] = (scan.hPos >= xStart);
        qCke[1] = (scan.hPos <= xEnd);
        qCke[2] = (scan.vPos >= yStart);
        qCke[3] = (scan.vPos <= yEnd);
    end

    always_ff @(posedge iClk)
    begin
        if (reset)
            rCke <= '0;
        else
            rCke <= qCke & {4{scan.active}};  // blanking never hits
    end

    always_ff @(posedge iClk)
    begin
        rColor <= color;
    end

    // ------------------------------------------------------
    // stage 2: combine, colour second delay
    // ------------------------------------------------------
    always_ff @(posedge iClk)
    begin
        if (reset)
            valid <= 1'b0;
        else
            valid <= &rCke;                 // empty range -> no hits
    end

    always_ff @(posedge iClk)
    begin
        pixel <= rColor;
    end

    // hits only come from the visible area
    validActiveA: assert property (@(posedge iClk) disable iff (reset)
        valid |-> $past(scan.active, 2));

endmodule

`default_nettype wire

//--- source/LayerMixer.sv
// ----------------------------------------------------------
// layer priority, blend and output register with sync delay
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module LayerMixer
    import PixelPkg::*;
(
    input  wire logic      iClk,
    input  wire logic      reset,
    ScanIf.dst             scan,        // active and syncs only
    input  wire pixelWordT fillPixel,
    input  wire logic      fillValid,
    input  wire pixelWordT framePixel,
    input  wire logic      frameValid,
    input  wire logic      fillEn,
    input  wire logic      frameEn,
    input  wire logic      blendEn,     // half fill, half background
    input  wire pixelWordT background,
    output pixelWordT      pixel,
    output logic           de,
    output logic           hSync,
    output logic           vSync
);

    // ------------------------------------------------------
    // control delay, two stages to meet the generators
    // ------------------------------------------------------
    logic [2:0] rCtlD1;                 // {active, hSync, vSync}
    logic [2:0] rCtlD2;

    always_ff @(posedge iClk)
    begin
        if (reset)
        begin
            rCtlD1 <= '0;
            rCtlD2 <= '0;
        end
        else
        begin
            rCtlD1 <= {scan.active, scan.hSync, scan.vSync};
            rCtlD2 <= rCtlD1;
        end
    end

    // ------------------------------------------------------
    // layer select, frame over fill over background
    // ------------------------------------------------------
    pixelWordT qPixel;

    always_comb
    begin
        if (frameValid && frameEn)
            qPixel = framePixel;
        else if (fillValid && fillEn)
            qPixel = blendEn ? avgPixel(fillPixel, background) : fillPixel;
        else
            qPixel = background;
    end

    // output stage, third cycle of the control delay
    always_ff @(posedge iClk)
    begin
        if (reset)
            {de, hSync, vSync} <= 3'b000;
        else
            {de, hSync, vSync} <= rCtlD2;
        pixel.raw <= rCtlD2[2] ? qPixel.raw : '0;   // black in blanking
    end

    blankPixelA: assert property (@(posedge iClk) disable iff (reset)
        !de |-> (pixel.raw == '0));

endmodule

`default_nettype wire

//--- source/PixelPkg.sv
// ----------------------------------------------------------
// RGB565 pixel word and the channel average helper
// ----------------------------------------------------------
`default_nettype none

`include "video_cfg.svh"

package PixelPkg;

    typedef union packed {
        logic [`COLOR_WIDTH-1:0] raw;   // muxing and outputs
        struct packed {
            logic [4:0] red;
            logic [5:0] green;
            logic [4:0] blue;
        } rgb;                          // per channel view for blending
    } pixelWordT;

    // per channel floor((a + b) / 2), one carry bit per channel
    function automatic pixelWordT avgPixel(input pixelWordT a, input pixelWordT b);
        logic [5:0] red;
        logic [6:0] green;
        logic [5:0] blue;
        pixelWordT  avg;
        red   = {1'b0, a.rgb.red}   + {1'b0, b.rgb.red};
        green = {1'b0, a.rgb.green} + {1'b0, b.rgb.green};
        blue  = {1'b0, a.rgb.blue}  + {1'b0, b.rgb.blue};
        avg.rgb.red   = red[5:1];       // drop lsb, rounds down
        avg.rgb.green = green[6:1];
        avg.rgb.blue  = blue[5:1];
        return avg;
    endfunction

endpackage

`default_nettype wire

//--- source/RectOverlayTop.sv
// ----------------------------------------------------------
// overlay top: timing, fill and frame generators, mixer
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module RectOverlayTop
    import VideoTimingPkg::*;
    import PixelPkg::*;
(
    input  wire logic       iClk,
    input  wire logic       reset,
    // filled rectangle
    input  wire hCoordT     fillXStart,
    input  wire hCoordT     fillXEnd,
    input  wire vCoordT     fillYStart,
    input  wire vCoordT     fillYEnd,
    input  wire pixelWordT  fillColor,
    // outlined rectangle
    input  wire hCoordT     frameXStart,
    input  wire hCoordT     frameXEnd,
    input  wire vCoordT     frameYStart,
    input  wire vCoordT     frameYEnd,
    input  wire pixelWordT  frameColor,
    input  wire logic [1:0] frameThickness,
    // mixing
    input  wire logic       fillEn,
    input  wire logic       frameEn,
    input  wire logic       blendEn,
    input  wire pixelWordT  background,
    // video out, 3 cycles behind the scan
    output pixelWordT       pixel,
    output logic            de,
    output logic            hSync,
    output logic            vSync
);

    ScanIf scanBus ();

    pixelWordT fillPixel;               // generator outputs at t+2
    logic      fillValid;
    pixelWordT framePixel;
    logic      frameValid;

    ScanTimingGen uTiming (.iClk(iClk), .reset(reset), .scan(scanBus));

    DotSquareGen uSquare (
        .iClk(iClk), .reset(reset), .scan(scanBus),
        .xStart(fillXStart), .xEnd(fillXEnd),
        .yStart(fillYStart), .yEnd(fillYEnd),
        .color(fillColor), .pixel(fillPixel), .valid(fillValid)
    );

    DotFrameGen uFrame (
        .iClk(iClk), .reset(reset), .scan(scanBus),
        .xStart(frameXStart), .xEnd(frameXEnd),
        .yStart(frameYStart), .yEnd(frameYEnd), .thickness(frameThickness),
        .color(frameColor), .pixel(framePixel), .valid(frameValid)
    );

    LayerMixer uMixer (
        .iClk(iClk), .reset(reset), .scan(scanBus),
        .fillPixel(fillPixel), .fillValid(fillValid),
        .framePixel(framePixel), .frameValid(frameValid),
        .fillEn(fillEn), .frameEn(frameEn), .blendEn(blendEn),
        .background(background),
        .pixel(pixel), .de(de), .hSync(hSync), .vSync(vSync)
    );

endmodule

`default_nettype wire

//--- source/ScanIf.sv
// ----------------------------------------------------------
// scan bus: position, active flag and sync pulses
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface ScanIf
    import VideoTimingPkg::*;
();

    hCoordT hPos;       // current column
    vCoordT vPos;       // current line
    logic   active;     // inside visible area
    logic   hSync;      // line sync, active high
    logic   vSync;      // frame sync, active high

    // timing generator side
    modport src (
        output hPos,
        output vPos,
        output active,
        output hSync,
        output vSync
    );

    // shape generators and mixer
    modport dst (
        input  hPos,
        input  vPos,
        input  active,
        input  hSync,
        input  vSync
    );

endinterface

`default_nettype wire

//--- source/ScanTimingGen.sv
// ----------------------------------------------------------
// free running raster counters with active and sync decode
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module ScanTimingGen
    import VideoTimingPkg::*;
(
    input  wire logic iClk,
    input  wire logic reset,        // sync, active high
    ScanIf.src        scan
);

    // ------------------------------------------------------
    // geometry from cfg
    // ------------------------------------------------------
    localparam int hTotal = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int vTotal = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;

    localparam hCoordT hLast      = hCoordT'(hTotal - 1);
    localparam hCoordT hActEnd    = hCoordT'(`H_ACTIVE);
    localparam hCoordT hSyncStart = hCoordT'(`H_ACTIVE + `H_FRONT);
    localparam hCoordT hSyncEnd   = hCoordT'(`H_ACTIVE + `H_FRONT + `H_SYNC);

    localparam vCoordT vLast      = vCoordT'(vTotal - 1);
    localparam vCoordT vActEnd    = vCoordT'(`V_ACTIVE);
    localparam vCoordT vSyncStart = vCoordT'(`V_ACTIVE + `V_FRONT);
    localparam vCoordT vSyncEnd   = vCoordT'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    // ------------------------------------------------------
    // next position
    // ------------------------------------------------------
    hCoordT qHPos;
    vCoordT qVPos;
    logic   qHWrap;             // last column of the line

    always_comb
    begin
        qHWrap = (scan.hPos == hLast);
        qHPos  = qHWrap ? '0 : scan.hPos + 1'b1;
        if (!qHWrap)
            qVPos = scan.vPos;                  // hold within line
        else if (scan.vPos == vLast)
            qVPos = '0;                         // end of frame
        else
            qVPos = scan.vPos + 1'b1;
    end

    // ------------------------------------------------------
    // registered outputs, decoded from the next position
    // so flags line up with hPos / vPos on the same cycle
    // ------------------------------------------------------
    always_ff @(posedge iClk)
    begin
        if (reset)
        begin
            scan.hPos   <= '0;
            scan.vPos   <= '0;
            scan.active <= 1'b1;                // (0,0) is visible
            scan.hSync  <= 1'b0;
            scan.vSync  <= 1'b0;
        end
        else
        begin
            scan.hPos   <= qHPos;
            scan.vPos   <= qVPos;
            scan.active <= (qHPos < hActEnd) && (qVPos < vActEnd);
            scan.hSync  <= (qHPos >= hSyncStart) && (qHPos < hSyncEnd);
            scan.vSync  <= (qVPos >= vSyncStart) && (qVPos < vSyncEnd);
        end
    end

    // counter must wrap before the line total
    hPosRangeA: assert property (@(posedge iClk) disable iff (reset)
        scan.hPos < hCoordT'(hTotal));

endmodule

`default_nettype wire

//--- source/VideoTimingPkg.sv
// ----------------------------------------------------------
// scan coordinate types for horizontal and vertical position
// ----------------------------------------------------------
`default_nettype none

`include "video_cfg.svh"

package VideoTimingPkg;

    // ------------------------------------------------------
    // raster coordinates
    // ------------------------------------------------------

    // column index, covers active area plus blanking
    typedef logic [`H_WIDTH-1:0] hCoordT;

    // line index, covers active lines plus blanking
    typedef logic [`V_WIDTH-1:0] vCoordT;

    // note: bounds given to the shape generators are also
    // plain coordinates of these types, inclusive on both
    // ends, so a start greater than the end gives an empty
    // shape without any extra flag

endpackage

`default_nettype wire

//--- source/video_cfg.svh
// ----------------------------------------------------------
// raster geometry, coordinate widths and pixel word width
// ----------------------------------------------------------
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// ----------------------------------------------------------
// horizontal timing, in pixels (22 per line)
// ----------------------------------------------------------
`define H_ACTIVE    16      // visible columns
`define H_FRONT     2       // front porch
`define H_SYNC      2       // sync pulse
`define H_BACK      2       // back porch

// ----------------------------------------------------------
// vertical timing, in lines (15 per frame)
// ----------------------------------------------------------
`define V_ACTIVE    12      // visible lines
`define V_FRONT     1
`define V_SYNC      1
`define V_BACK      1

// counter widths, must cover the totals above
`define H_WIDTH     6       // 0..21
`define V_WIDTH     5       // 0..14

// RGB565 word
`define COLOR_WIDTH 16

`endif

//--- tests/ClockGen.sv
// ----------------------------------------------------------
// testbench clock, 4 ns period, reset held for 16 cycles
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ClockGen
(
    output logic iClk,
    output logic reset
);

    initial
    begin
        iClk = 1'b0;
        forever #2 iClk = ~iClk;    // 250 MHz
    end

    // release 1 ns after the 16th rising edge, like all other inputs
    initial
    begin
        reset = 1'b1;
        repeat (16) @(posedge iClk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/RectOverlayTb.sv
// ----------------------------------------------------------
// overlay testbench with pattern file stimulus and pixel checks
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "video_cfg.svh"

module RectOverlayTb
    import VideoTimingPkg::*;
    import PixelPkg::*;
();

    localparam int hTotal     = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int vTotal     = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int frameLimit = 2 * hTotal * vTotal;    // cycles
    localparam int lineLimit  = 3 * hTotal;

    logic       iClk;
    logic       reset;
    hCoordT     fillXStart;
    hCoordT     fillXEnd;
    vCoordT     fillYStart;
    vCoordT     fillYEnd;
    pixelWordT  fillColor;
    hCoordT     frameXStart;
    hCoordT     frameXEnd;
    vCoordT     frameYStart;
    vCoordT     frameYEnd;
    pixelWordT  frameColor;
    logic [1:0] frameThickness;
    logic       fillEn;
    logic       frameEn;
    logic       blendEn;
    pixelWordT  background;
    pixelWordT  pixel;
    logic       de;
    logic       hSync;
    logic       vSync;

    int pat [17];               // one pattern line in file column order

    ClockGen uClock (.iClk(iClk), .reset(reset));

    RectOverlayTop i_dut (
        .iClk(iClk), .reset(reset),
        .fillXStart(fillXStart), .fillXEnd(fillXEnd),
        .fillYStart(fillYStart), .fillYEnd(fillYEnd), .fillColor(fillColor),
        .frameXStart(frameXStart), .frameXEnd(frameXEnd),
        .frameYStart(frameYStart), .frameYEnd(frameYEnd),
        .frameColor(frameColor), .frameThickness(frameThickness),
        .fillEn(fillEn), .frameEn(frameEn), .blendEn(blendEn),
        .background(background),
        .pixel(pixel), .de(de), .hSync(hSync), .vSync(vSync)
    );

    // ------------------------------------------------------
    // error handling and cycle stepping
    // ------------------------------------------------------
    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected)
            stopOnError($sformatf("mismatch at %0t: %s got 0x%0h, expected 0x%0h",
                                  $time, name, got, expected));
    endtask

    // sample and drive 1 ns after the rising edge
    task automatic stepCycle();
        @(posedge iClk);
        #1;
    endtask

    // ------------------------------------------------------
    // reference model of the layers
    // ------------------------------------------------------
    function automatic bit inFill(input int x, input int y);
        return (x >= int'(fillXStart)) && (x <= int'(fillXEnd))
            && (y >= int'(fillYStart)) && (y <= int'(fillYEnd));
    endfunction

    function automatic bit onFrame(input int x, input int y);
        int xs;
        int xe;
        int ys;
        int ye;
        int t;
        xs = int'(frameXStart);
        xe = int'(frameXEnd);
        ys = int'(frameYStart);
        ye = int'(frameYEnd);
        t  = int'(frameThickness);
        if (x < xs || x > xe || y < ys || y > ye)
            return 1'b0;                        // outside outer box
        return (x - xs < t) || (xe - x < t) || (y - ys < t) || (ye - y < t);
    endfunction

    // 2 for frame, 1 for fill or blend and 0 for background
    function automatic int layerAt(input int x, input int y);
        int layer;
        layer = 0;
        if (frameEn && onFrame(x, y))
            layer = 2;
        else if (fillEn && inFill(x, y))
            layer = 1;
        return layer;
    endfunction

    // per channel RGB565 average rounded down
    function automatic logic [`COLOR_WIDTH-1:0] blendColor(
        input logic [`COLOR_WIDTH-1:0] a, input logic [`COLOR_WIDTH-1:0] b);
        int red;
        int green;
        int blue;
        red   = (int'(a[15:11]) + int'(b[15:11])) / 2;
        green = (int'(a[10:5])  + int'(b[10:5]))  / 2;
        blue  = (int'(a[4:0])   + int'(b[4:0]))   / 2;
        return {red[4:0], green[5:0], blue[4:0]};
    endfunction

    // ------------------------------------------------------
    // bounded waits
    // ------------------------------------------------------
    task automatic waitResetDone();
        int n;
        n = 0;
        stepCycle();
        while (reset)
        begin
            n++;
            if (n > 64)
                stopOnError("reset was not released within 64 cycles");
            stepCycle();
        end
    endtask

    task automatic waitVSyncRise();
        int   n;
        logic prev;
        n    = 0;
        prev = vSync;
        stepCycle();
        while (!(vSync && !prev))
        begin
            prev = vSync;
            n++;
            if (n > frameLimit)
                stopOnError("no rising edge of vSync within two frame times");
            stepCycle();
        end
    endtask

    // wait for the next de run and expect an hSync between active lines
    task automatic waitLineStart(input bit innerLine);
        int n;
        bit sawHSync;
        n        = 0;
        sawHSync = 1'b0;
        while (!de)
        begin
            if (hSync)
                sawHSync = 1'b1;
            if (innerLine && vSync)
                stopOnError("vSync pulsed between two active lines");
            n++;
            if (n > lineLimit)
                stopOnError("de did not rise within three line times");
            stepCycle();
        end
        if (innerLine && !sawHSync)
            stopOnError("two active lines came without an hSync pulse between them");
    endtask

    // ------------------------------------------------------
    // one full frame against the model
    // ------------------------------------------------------
    task automatic checkFrame(input int expFrame, input int expFill);
        int x;
        int y;
        int n;
        int layer;
        int frameCnt;
        int fillCnt;
        logic [`COLOR_WIDTH-1:0] expected;
        frameCnt = 0;
        fillCnt  = 0;
        waitVSyncRise();
        for (y = 0; y < `V_ACTIVE; y++)
        begin
            waitLineStart(y > 0);
            for (x = 0; x < `H_ACTIVE; x++)
            begin
                layer = layerAt(x, y);
                case (layer)
                    2:       expected = frameColor.raw;
                    1:       expected = blendEn ? blendColor(fillColor.raw, background.raw)
                                                : fillColor.raw;
                    default: expected = background.raw;
                endcase
                if (layer == 2)
                    frameCnt++;
                else if (layer == 1)
                    fillCnt++;
                checkValue("de", 32'(de), 32'd1);
                checkValue("hSync", 32'(hSync), 32'd0);
                checkValue("vSync", 32'(vSync), 32'd0);
                checkValue($sformatf("pixel(%0d,%0d)", x, y), 32'(pixel.raw), 32'(expected));
                stepCycle();
            end
            checkValue("de", 32'(de), 32'd0);    // run is exactly 16 wide
        end
        // no 13th line before the next frame sync
        n = 0;
        while (!vSync)
        begin
            checkValue("de", 32'(de), 32'd0);
            n++;
            if (n > lineLimit)
                stopOnError("vSync did not follow the last active line");
            stepCycle();
        end
        checkValue("frame pixel count", 32'(frameCnt), 32'(expFrame));
        checkValue("fill pixel count", 32'(fillCnt), 32'(expFill));
    endtask

    // ------------------------------------------------------
    // pattern file
    // ------------------------------------------------------
    task automatic readPattern(input int fd, output int got);
        got = $fscanf(fd, "%d %d %d %d %h %d %d %d %d %h %d %d %d %d %h %d %d",
                      pat[0], pat[1], pat[2], pat[3], pat[4], pat[5], pat[6],
                      pat[7], pat[8], pat[9], pat[10], pat[11], pat[12],
                      pat[13], pat[14], pat[15], pat[16]);
    endtask

    task automatic applyPattern();
        stepCycle();
        fillXStart      = hCoordT'(pat[0]);
        fillXEnd        = hCoordT'(pat[1]);
        fillYStart      = vCoordT'(pat[2]);
        fillYEnd        = vCoordT'(pat[3]);
        fillColor.raw   = 16'(pat[4]);
        frameXStart     = hCoordT'(pat[5]);
        frameXEnd       = hCoordT'(pat[6]);
        frameYStart     = vCoordT'(pat[7]);
        frameYEnd       = vCoordT'(pat[8]);
        frameColor.raw  = 16'(pat[9]);
        frameThickness  = 2'(pat[10]);
        fillEn          = (pat[11] != 0);
        frameEn         = (pat[12] != 0);
        blendEn         = (pat[13] != 0);
        background.raw  = 16'(pat[14]);
    endtask

    initial
    begin
        int fd;
        int got;
        int caseNum;
        fillXStart     = '0;
        fillXEnd       = '0;
        fillYStart     = '0;
        fillYEnd       = '0;
        fillColor.raw  = '0;
        frameXStart    = '0;
        frameXEnd      = '0;
        frameYStart    = '0;
        frameYEnd      = '0;
        frameColor.raw = '0;
        frameThickness = 2'd1;          // 0 is illegal for the frame
        fillEn         = 1'b0;
        frameEn        = 1'b0;
        blendEn        = 1'b0;
        background.raw = '0;
        caseNum        = 0;
        fd = $fopen("tests/rect_patterns.txt", "r");
        if (fd == 0)
            stopOnError("could not open tests/rect_patterns.txt");
        waitResetDone();
        readPattern(fd, got);
        while (got == 17)
        begin
            caseNum++;
            applyPattern();
            checkFrame(pat[15], pat[16]);
            $display("case %0d: frame %0d, fill %0d pixels", caseNum, pat[15], pat[16]);
            readPattern(fd, got);
        end
        if (!$feof(fd) || caseNum == 0)
            stopOnError("pattern file has a malformed line or holds no cases");
        else
        begin
            $fclose(fd);
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/rect_patterns.txt
2 5 1 3 f800 0 3 0 3 07e0 1 1 0 0 001f 0 12
0 15 10 11 f800 0 3 0 3 07e0 1 1 0 0 001f 0 32
15 15 0 11 ffe0 0 3 0 3 07e0 1 1 0 0 0010 0 12
9 4 2 7 f800 0 3 0 3 07e0 1 1 0 0 001f 0 0
0 0 0 0 0000 2 9 1 6 07e0 1 0 1 0 0841 24 0
0 0 0 0 0000 0 15 0 11 ffff 2 0 1 0 0841 96 0
0 0 0 0 0000 3 12 2 10 f81f 3 0 1 0 0841 78 0
4 11 3 8 07e0 2 7 1 5 ffff 1 1 1 0 2104 18 42
1 14 2 9 f81f 0 3 0 3 07e0 1 1 0 1 07ff 0 112
3 8 2 6 8410 0 5 0 3 ffe0 2 1 1 1 4a69 24 24
2 5 1 3 f800 2 9 1 6 07e0 1 0 0 0 5555 0 0
